// ==== source/riscv_em_config.svh ====
`ifndef RISCV_EM_CONFIG_SVH
`define RISCV_EM_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Register and data path width.
`define RISCV_EM_XLEN 64

// Doubleword index bits of the data memory.
`define RISCV_EM_DMEM_ADDR_BITS 6

// Byte offset bits inside one doubleword.
`define RISCV_EM_BYTE_OFS_BITS 3

// Byte lanes per doubleword.
`define RISCV_EM_BYTE_LANES 8

`endif

// ==== source/riscv_em_pkg.sv ====
`default_nettype none

package riscv_em_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes seen by the memory stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Load extension, same code as funct3 of the load.
    typedef enum logic [2:0] {
        EXT_B  = 3'b000,
        EXT_H  = 3'b001,
        EXT_W  = 3'b010,
        EXT_D  = 3'b011,
        EXT_BU = 3'b100,
        EXT_HU = 3'b101,
        EXT_WU = 3'b110
    } memext_e;

    typedef enum logic [1:0] {
        ST_B = 2'b00, // Byte.
        ST_H = 2'b01, // Halfword.
        ST_W = 2'b10, // Word.
        ST_D = 2'b11  // Doubleword.
    } storesrc_e;

    typedef enum logic [2:0] {
        RES_ALU = 3'b000,
        RES_MEM = 3'b001,
        RES_PC4 = 3'b010,
        RES_IMM = 3'b011
    } resultsrc_e;

endpackage

`default_nettype wire

// ==== source/riscv_ppreg_em.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_em_config.svh"

module riscv_ppreg_em (
    input  wire logic                            i_riscv_em_clk,
    input  wire logic                            i_riscv_em_rst,
    input  wire logic                            i_riscv_em_en,     // High holds the stage.
    input  wire logic                            i_riscv_em_flush,
    input  wire logic                            i_riscv_em_regw_e,
    input  riscv_em_pkg::resultsrc_e             i_riscv_em_resultsrc_e,
    input  riscv_em_pkg::storesrc_e              i_riscv_em_storesrc_e,
    input  riscv_em_pkg::memext_e                i_riscv_em_memext_e,
    input  riscv_em_pkg::opcode_e                i_riscv_em_opcode_e,
    input  wire logic [4:0]                      i_riscv_em_rdaddr_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_riscv_em_result_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_riscv_em_storedata_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_riscv_em_pcplus4_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_riscv_em_imm_e,
    input  wire logic                            i_riscv_em_load_misaligned_e,
    input  wire logic                            i_riscv_em_store_misaligned_e,
    output logic                                 o_riscv_em_regw_m,
    output riscv_em_pkg::resultsrc_e             o_riscv_em_resultsrc_m,
    output riscv_em_pkg::storesrc_e              o_riscv_em_storesrc_m,
    output riscv_em_pkg::memext_e                o_riscv_em_memext_m,
    output riscv_em_pkg::opcode_e                o_riscv_em_opcode_m,
    output logic [4:0]                           o_riscv_em_rdaddr_m,
    output logic [`RISCV_EM_XLEN-1:0]            o_riscv_em_result_m,
    output logic [`RISCV_EM_XLEN-1:0]            o_riscv_em_storedata_m,
    output logic [`RISCV_EM_XLEN-1:0]            o_riscv_em_pcplus4_m,
    output logic [`RISCV_EM_XLEN-1:0]            o_riscv_em_imm_m,
    output logic                                 o_riscv_em_load_misaligned_m,
    output logic                                 o_riscv_em_store_misaligned_m
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset, then flush to bubble, then capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_riscv_em_regw_m             <= 1'b0;
            o_riscv_em_resultsrc_m        <= riscv_em_pkg::RES_ALU;
            o_riscv_em_storesrc_m         <= riscv_em_pkg::ST_B;
            o_riscv_em_memext_m           <= riscv_em_pkg::EXT_B;
            o_riscv_em_opcode_m           <= riscv_em_pkg::opcode_e'(7'd0);
            o_riscv_em_rdaddr_m           <= '0;
            o_riscv_em_result_m           <= '0;
            o_riscv_em_storedata_m        <= '0;
            o_riscv_em_pcplus4_m          <= '0;
            o_riscv_em_imm_m              <= '0;
            o_riscv_em_load_misaligned_m  <= 1'b0;
            o_riscv_em_store_misaligned_m <= 1'b0;
        end
        else if (i_riscv_em_flush)
        begin
            // Opcode zero is neither load nor store.
            o_riscv_em_regw_m             <= 1'b0;
            o_riscv_em_resultsrc_m        <= riscv_em_pkg::RES_ALU;
            o_riscv_em_storesrc_m         <= riscv_em_pkg::ST_B;
            o_riscv_em_memext_m           <= riscv_em_pkg::EXT_B;
            o_riscv_em_opcode_m           <= riscv_em_pkg::opcode_e'(7'd0);
            o_riscv_em_rdaddr_m           <= '0;
            o_riscv_em_result_m           <= '0;
            o_riscv_em_storedata_m        <= '0;
            o_riscv_em_pcplus4_m          <= '0;
            o_riscv_em_imm_m              <= '0;
            o_riscv_em_load_misaligned_m  <= 1'b0;
            o_riscv_em_store_misaligned_m <= 1'b0;
        end
        else if (!i_riscv_em_en)
        begin
            o_riscv_em_regw_m             <= i_riscv_em_regw_e;
            o_riscv_em_resultsrc_m        <= i_riscv_em_resultsrc_e;
            o_riscv_em_storesrc_m         <= i_riscv_em_storesrc_e;
            o_riscv_em_memext_m           <= i_riscv_em_memext_e;
            o_riscv_em_opcode_m           <= i_riscv_em_opcode_e;
            o_riscv_em_rdaddr_m           <= i_riscv_em_rdaddr_e;
            o_riscv_em_result_m           <= i_riscv_em_result_e;
            o_riscv_em_storedata_m        <= i_riscv_em_storedata_e;
            o_riscv_em_pcplus4_m          <= i_riscv_em_pcplus4_e;
            o_riscv_em_imm_m              <= i_riscv_em_imm_e;
            o_riscv_em_load_misaligned_m  <= i_riscv_em_load_misaligned_e;
            o_riscv_em_store_misaligned_m <= i_riscv_em_store_misaligned_e;
        end
    end

endmodule

`default_nettype wire

// ==== source/riscv_store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_em_config.svh"

module riscv_store_align (
    input  riscv_em_pkg::opcode_e                      i_opcode,
    input  riscv_em_pkg::storesrc_e                    i_storesrc,
    input  wire logic                                  i_store_misaligned,
    input  wire logic [`RISCV_EM_XLEN-1:0]             i_addr,
    input  wire logic [`RISCV_EM_XLEN-1:0]             i_storedata,
    output logic                                       o_we,
    output logic [`RISCV_EM_BYTE_LANES-1:0]            o_byte_en,
    output logic [`RISCV_EM_DMEM_ADDR_BITS-1:0]        o_index,
    output logic [`RISCV_EM_XLEN-1:0]                  o_wdata
);

    logic [`RISCV_EM_BYTE_OFS_BITS-1:0] byte_ofs;
    logic [`RISCV_EM_BYTE_LANES-1:0]    size_mask;

    assign byte_ofs = i_addr[`RISCV_EM_BYTE_OFS_BITS-1:0];

    // Lanes covered by the access at offset zero.
    always_comb
    begin
        case (i_storesrc)
            riscv_em_pkg::ST_B: size_mask = 8'h01;
            riscv_em_pkg::ST_H: size_mask = 8'h03;
            riscv_em_pkg::ST_W: size_mask = 8'h0f;
            default:            size_mask = 8'hff;
        endcase
    end

    // A flagged store never reaches memory.
    assign o_we      = (i_opcode == riscv_em_pkg::OPC_STORE) && !i_store_misaligned;
    assign o_byte_en = size_mask << byte_ofs;
    assign o_wdata   = i_storedata << {byte_ofs, 3'b000}; // Move data onto its byte lanes.
    assign o_index   = i_addr[`RISCV_EM_DMEM_ADDR_BITS+`RISCV_EM_BYTE_OFS_BITS-1:
                              `RISCV_EM_BYTE_OFS_BITS];

endmodule

`default_nettype wire

// ==== source/riscv_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_em_config.svh"

module riscv_dmem (
    input  wire logic                                  i_riscv_em_clk,
    input  wire logic                                  i_we,
    input  wire logic [`RISCV_EM_BYTE_LANES-1:0]       i_byte_en,
    input  wire logic [`RISCV_EM_DMEM_ADDR_BITS-1:0]   i_index,
    input  wire logic [`RISCV_EM_XLEN-1:0]             i_wdata,
    output logic [`RISCV_EM_XLEN-1:0]                  o_rdata
);

    localparam int DEPTH = 1 << `RISCV_EM_DMEM_ADDR_BITS;

    logic [`RISCV_EM_XLEN-1:0] mem [DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte-enabled write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_riscv_em_clk)
    begin
        if (i_we)
        begin
            for (int b = 0; b < `RISCV_EM_BYTE_LANES; b++)
            begin
                if (i_byte_en[b])
                begin
                    mem[i_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read, so a load sees last cycle's store.
    assign o_rdata = mem[i_index];

endmodule

`default_nettype wire

// ==== source/riscv_mem_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_em_config.svh"

module riscv_mem_result (
    input  riscv_em_pkg::opcode_e                i_opcode,
    input  riscv_em_pkg::memext_e                i_memext,
    input  riscv_em_pkg::resultsrc_e             i_resultsrc,
    input  wire logic                            i_regw,
    input  wire logic [4:0]                      i_rdaddr,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_result,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_pcplus4,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_imm,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_rdata,
    input  wire logic                            i_load_misaligned,
    input  wire logic                            i_store_misaligned,
    output logic                                 o_wb_regw,
    output logic [4:0]                           o_wb_rdaddr,
    output logic [`RISCV_EM_XLEN-1:0]            o_wb_data,
    output logic                                 o_trap
);

    localparam int XLEN = `RISCV_EM_XLEN;

    logic [`RISCV_EM_BYTE_OFS_BITS-1:0] byte_ofs;
    logic [XLEN-1:0]                    rd_shifted;
    logic [XLEN-1:0]                    load_data;

    assign byte_ofs   = i_result[`RISCV_EM_BYTE_OFS_BITS-1:0];
    assign rd_shifted = i_rdata >> {byte_ofs, 3'b000}; // Addressed byte to lane 0.

    always_comb
    begin
        case (i_memext)
            riscv_em_pkg::EXT_B:  load_data = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            riscv_em_pkg::EXT_H:  load_data = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            riscv_em_pkg::EXT_W:  load_data = {{(XLEN-32){rd_shifted[31]}}, rd_shifted[31:0]};
            riscv_em_pkg::EXT_BU: load_data = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
            riscv_em_pkg::EXT_HU: load_data = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
            riscv_em_pkg::EXT_WU: load_data = {{(XLEN-32){1'b0}}, rd_shifted[31:0]};
            default:              load_data = rd_shifted;
        endcase
    end

    // Writeback source.
    always_comb
    begin
        case (i_resultsrc)
            riscv_em_pkg::RES_MEM: o_wb_data = load_data;
            riscv_em_pkg::RES_PC4: o_wb_data = i_pcplus4;
            riscv_em_pkg::RES_IMM: o_wb_data = i_imm;
            default:               o_wb_data = i_result;
        endcase
    end

    assign o_trap = ((i_opcode == riscv_em_pkg::OPC_LOAD) && i_load_misaligned) ||
                    ((i_opcode == riscv_em_pkg::OPC_STORE) && i_store_misaligned);

    assign o_wb_regw   = i_regw && (i_rdaddr != 5'd0) && !o_trap; // x0 stays zero.
    assign o_wb_rdaddr = i_rdaddr;

endmodule

`default_nettype wire

// ==== source/riscv_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_em_config.svh"

module riscv_mem_stage (
    input  wire logic                            i_riscv_em_clk,
    input  wire logic                            i_riscv_em_rst,
    input  wire logic                            i_riscv_em_en,
    input  wire logic                            i_flush,
    input  wire logic                            i_regw_e,
    input  riscv_em_pkg::resultsrc_e             i_resultsrc_e,
    input  riscv_em_pkg::storesrc_e              i_storesrc_e,
    input  riscv_em_pkg::memext_e                i_memext_e,
    input  riscv_em_pkg::opcode_e                i_opcode_e,
    input  wire logic [4:0]                      i_rdaddr_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_result_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_storedata_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_pcplus4_e,
    input  wire logic [`RISCV_EM_XLEN-1:0]       i_imm_e,
    input  wire logic                            i_load_misaligned_e,
    input  wire logic                            i_store_misaligned_e,
    output logic                                 o_wb_regw,
    output logic [4:0]                           o_wb_rdaddr,
    output logic [`RISCV_EM_XLEN-1:0]            o_wb_data,
    output logic                                 o_trap
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // M-stage fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic                                  regw_m;
    riscv_em_pkg::resultsrc_e              resultsrc_m;
    riscv_em_pkg::storesrc_e               storesrc_m;
    riscv_em_pkg::memext_e                 memext_m;
    riscv_em_pkg::opcode_e                 opcode_m;
    logic [4:0]                            rdaddr_m;
    logic [`RISCV_EM_XLEN-1:0]             result_m;
    logic [`RISCV_EM_XLEN-1:0]             storedata_m;
    logic [`RISCV_EM_XLEN-1:0]             pcplus4_m;
    logic [`RISCV_EM_XLEN-1:0]             imm_m;
    logic                                  load_misaligned_m;
    logic                                  store_misaligned_m;

    // Memory port.
    logic                                  dmem_we;
    logic [`RISCV_EM_BYTE_LANES-1:0]       dmem_byte_en;
    logic [`RISCV_EM_DMEM_ADDR_BITS-1:0]   dmem_index;
    logic [`RISCV_EM_XLEN-1:0]             dmem_wdata;
    logic [`RISCV_EM_XLEN-1:0]             dmem_rdata;

    riscv_ppreg_em u_ppreg_em (
        .i_riscv_em_clk                (i_riscv_em_clk),
        .i_riscv_em_rst                (i_riscv_em_rst),
        .i_riscv_em_en                 (i_riscv_em_en),
        .i_riscv_em_flush              (i_flush),
        .i_riscv_em_regw_e             (i_regw_e),
        .i_riscv_em_resultsrc_e        (i_resultsrc_e),
        .i_riscv_em_storesrc_e         (i_storesrc_e),
        .i_riscv_em_memext_e           (i_memext_e),
        .i_riscv_em_opcode_e           (i_opcode_e),
        .i_riscv_em_rdaddr_e           (i_rdaddr_e),
        .i_riscv_em_result_e           (i_result_e),
        .i_riscv_em_storedata_e        (i_storedata_e),
        .i_riscv_em_pcplus4_e          (i_pcplus4_e),
        .i_riscv_em_imm_e              (i_imm_e),
        .i_riscv_em_load_misaligned_e  (i_load_misaligned_e),
        .i_riscv_em_store_misaligned_e (i_store_misaligned_e),
        .o_riscv_em_regw_m             (regw_m),
        .o_riscv_em_resultsrc_m        (resultsrc_m),
        .o_riscv_em_storesrc_m         (storesrc_m),
        .o_riscv_em_memext_m           (memext_m),
        .o_riscv_em_opcode_m           (opcode_m),
        .o_riscv_em_rdaddr_m           (rdaddr_m),
        .o_riscv_em_result_m           (result_m),
        .o_riscv_em_storedata_m        (storedata_m),
        .o_riscv_em_pcplus4_m          (pcplus4_m),
        .o_riscv_em_imm_m              (imm_m),
        .o_riscv_em_load_misaligned_m  (load_misaligned_m),
        .o_riscv_em_store_misaligned_m (store_misaligned_m)
    );

    // ALU result doubles as the data address.
    riscv_store_align u_store_align (
        .i_opcode           (opcode_m),
        .i_storesrc         (storesrc_m),
        .i_store_misaligned (store_misaligned_m),
        .i_addr             (result_m),
        .i_storedata        (storedata_m),
        .o_we               (dmem_we),
        .o_byte_en          (dmem_byte_en),
        .o_index            (dmem_index),
        .o_wdata            (dmem_wdata)
    );

    riscv_dmem u_dmem (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_we           (dmem_we),
        .i_byte_en      (dmem_byte_en),
        .i_index        (dmem_index),
        .i_wdata        (dmem_wdata),
        .o_rdata        (dmem_rdata)
    );

    riscv_mem_result u_mem_result (
        .i_opcode           (opcode_m),
        .i_memext           (memext_m),
        .i_resultsrc        (resultsrc_m),
        .i_regw             (regw_m),
        .i_rdaddr           (rdaddr_m),
        .i_result           (result_m),
        .i_pcplus4          (pcplus4_m),
        .i_imm              (imm_m),
        .i_rdata            (dmem_rdata),
        .i_load_misaligned  (load_misaligned_m),
        .i_store_misaligned (store_misaligned_m),
        .o_wb_regw          (o_wb_regw),
        .o_wb_rdaddr        (o_wb_rdaddr),
        .o_wb_data          (o_wb_data),
        .o_trap             (o_trap)
    );

endmodule

`default_nettype wire

// ==== verification/riscv_mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_em_config.svh"

module riscv_mem_checker (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst,
    input  wire logic                      i_stall,
    input  wire logic                      i_flush,
    input  wire logic                      i_regw_e,
    input  wire logic [2:0]                i_resultsrc_e,
    input  wire logic [1:0]                i_storesrc_e,
    input  wire logic [2:0]                i_memext_e,
    input  wire logic [6:0]                i_opcode_e,
    input  wire logic [4:0]                i_rdaddr_e,
    input  wire logic [`RISCV_EM_XLEN-1:0] i_result_e,
    input  wire logic [`RISCV_EM_XLEN-1:0] i_storedata_e,
    input  wire logic [`RISCV_EM_XLEN-1:0] i_pcplus4_e,
    input  wire logic [`RISCV_EM_XLEN-1:0] i_imm_e,
    input  wire logic                      i_load_misaligned_e,
    input  wire logic                      i_store_misaligned_e,
    input  wire logic                      i_wb_regw,
    input  wire logic [4:0]                i_wb_rdaddr,
    input  wire logic [`RISCV_EM_XLEN-1:0] i_wb_data,
    input  wire logic                      i_trap,
    output int                             o_error_count,
    output int                             o_check_count
);

    localparam int XLEN      = `RISCV_EM_XLEN;
    localparam int ABITS     = `RISCV_EM_DMEM_ADDR_BITS + `RISCV_EM_BYTE_OFS_BITS;
    localparam int MEM_BYTES = 1 << ABITS;

    // Model of the M-stage register.
    logic            m_regw;
    logic [2:0]      m_resultsrc;
    logic [1:0]      m_storesrc;
    logic [2:0]      m_memext;
    logic [6:0]      m_opcode;
    logic [4:0]      m_rd;
    logic [XLEN-1:0] m_result;
    logic [XLEN-1:0] m_storedata;
    logic [XLEN-1:0] m_pcplus4;
    logic [XLEN-1:0] m_imm;
    logic            m_ld_mis;
    logic            m_st_mis;
    logic            exp_trap;
    logic            exp_regw;
    logic [7:0]      mirror [MEM_BYTES]; // Byte-addressed copy of the data memory.

    initial
    begin
        o_error_count = 0;
        o_check_count = 0;
    end

    task automatic clear_model();
        m_regw      = 1'b0;
        m_resultsrc = '0;
        m_storesrc  = '0;
        m_memext    = '0;
        m_opcode    = '0; // Bubble.
        m_rd        = '0;
        m_result    = '0;
        m_storedata = '0;
        m_pcplus4   = '0;
        m_imm       = '0;
        m_ld_mis    = 1'b0;
        m_st_mis    = 1'b0;
    endtask

    // Low two bits of the extension code give log2 of the size. Bit 2 marks unsigned.
    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] addr,
                                                   input logic [2:0] ext);
        int              nbytes;
        logic [ABITS-1:0] base;
        logic [XLEN-1:0] v;
        nbytes = 1 << ext[1:0];
        base   = addr[ABITS-1:0];
        v      = '0;
        for (int k = 0; k < nbytes; k++)
            v[k*8 +: 8] = mirror[base + ABITS'(k)];
        if (!ext[2] && v[nbytes*8-1])
        begin
            for (int b = nbytes * 8; b < XLEN; b++)
                v[b] = 1'b1;
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] writeback_value();
        case (m_resultsrc)
            riscv_em_pkg::RES_MEM: return load_value(m_result, m_memext);
            riscv_em_pkg::RES_PC4: return m_pcplus4;
            riscv_em_pkg::RES_IMM: return m_imm;
            default:               return m_result;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
        o_check_count++;
        if (act !== exp)
        begin
            o_error_count++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model update at the rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            clear_model();
        end
        else
        begin
            if ((m_opcode == riscv_em_pkg::OPC_STORE) && !m_st_mis)
            begin
                for (int k = 0; k < (1 << m_storesrc); k++)
                    mirror[m_result[ABITS-1:0] + ABITS'(k)] = m_storedata[k*8 +: 8];
            end
            if (i_flush)
                clear_model();
            else if (!i_stall)
            begin
                m_regw      = i_regw_e;
                m_resultsrc = i_resultsrc_e;
                m_storesrc  = i_storesrc_e;
                m_memext    = i_memext_e;
                m_opcode    = i_opcode_e;
                m_rd        = i_rdaddr_e;
                m_result    = i_result_e;
                m_storedata = i_storedata_e;
                m_pcplus4   = i_pcplus4_e;
                m_imm       = i_imm_e;
                m_ld_mis    = i_load_misaligned_e;
                m_st_mis    = i_store_misaligned_e;
            end
        end
    end

    // Outputs only move at rising edges, so the falling edge sees them settled.
    always @(negedge i_clk)
    begin
        exp_trap = ((m_opcode == riscv_em_pkg::OPC_LOAD) && m_ld_mis) ||
                   ((m_opcode == riscv_em_pkg::OPC_STORE) && m_st_mis);
        exp_regw = m_regw && (m_rd != 5'd0) && !exp_trap;
        compare_value("o_trap", XLEN'(exp_trap), XLEN'(i_trap));
        compare_value("o_wb_regw", XLEN'(exp_regw), XLEN'(i_wb_regw));
        if (exp_regw)
        begin
            compare_value("o_wb_rdaddr", XLEN'(m_rd), XLEN'(i_wb_rdaddr));
            compare_value("o_wb_data", writeback_value(), i_wb_data);
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_riscv_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_em_config.svh"

module tb_riscv_mem_stage;

    localparam int XLEN         = `RISCV_EM_XLEN;
    localparam int ABITS        = `RISCV_EM_DMEM_ADDR_BITS + `RISCV_EM_BYTE_OFS_BITS;
    localparam int DWORDS       = 1 << `RISCV_EM_DMEM_ADDR_BITS;
    localparam int NUM_INSTR    = 2000;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = 2 * (NUM_INSTR + DWORDS) + RESET_CYCLES + 100;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     stall;
    logic                     flush;
    logic                     regw;
    riscv_em_pkg::resultsrc_e resultsrc;
    riscv_em_pkg::storesrc_e  storesrc;
    riscv_em_pkg::memext_e    memext;
    riscv_em_pkg::opcode_e    opcode;
    logic [4:0]               rdaddr;
    logic [XLEN-1:0]          result;
    logic [XLEN-1:0]          storedata;
    logic [XLEN-1:0]          pcplus4;
    logic [XLEN-1:0]          imm;
    logic                     ld_mis;
    logic                     st_mis;
    logic                     wb_regw;
    logic [4:0]               wb_rdaddr;
    logic [XLEN-1:0]          wb_data;
    logic                     trap;
    logic [XLEN-1:0]          last_addr;
    integer                   seed;
    int                       issued;
    int                       cycles;
    int                       err_count;
    int                       chk_count;

    riscv_mem_stage dut (
        .i_riscv_em_clk (clk),       .i_riscv_em_rst (rst),
        .i_riscv_em_en  (stall),     .i_flush        (flush),
        .i_regw_e       (regw),      .i_resultsrc_e  (resultsrc),
        .i_storesrc_e   (storesrc),  .i_memext_e     (memext),
        .i_opcode_e     (opcode),    .i_rdaddr_e     (rdaddr),
        .i_result_e     (result),    .i_storedata_e  (storedata),
        .i_pcplus4_e    (pcplus4),   .i_imm_e        (imm),
        .i_load_misaligned_e (ld_mis), .i_store_misaligned_e (st_mis),
        .o_wb_regw (wb_regw), .o_wb_rdaddr (wb_rdaddr), .o_wb_data (wb_data), .o_trap (trap)
    );

    riscv_mem_checker u_checker (
        .i_clk (clk), .i_rst (rst), .i_stall (stall), .i_flush (flush),
        .i_regw_e (regw), .i_resultsrc_e (resultsrc), .i_storesrc_e (storesrc),
        .i_memext_e (memext), .i_opcode_e (opcode), .i_rdaddr_e (rdaddr),
        .i_result_e (result), .i_storedata_e (storedata), .i_pcplus4_e (pcplus4),
        .i_imm_e (imm), .i_load_misaligned_e (ld_mis), .i_store_misaligned_e (st_mis),
        .i_wb_regw (wb_regw), .i_wb_rdaddr (wb_rdaddr), .i_wb_data (wb_data),
        .i_trap (trap), .o_error_count (err_count), .o_check_count (chk_count)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not end within %0d cycles.", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] a);
        return {~a[31:0] ^ 32'h5a5a0f0f, a[31:0] * 32'h01000193 + 32'h13579bdf};
    endfunction

    task automatic clear_inputs();
        {stall, flush, regw, ld_mis, st_mis} = '0;
        resultsrc = riscv_em_pkg::RES_ALU;
        storesrc  = riscv_em_pkg::ST_B;
        memext    = riscv_em_pkg::EXT_B;
        opcode    = riscv_em_pkg::opcode_e'(7'd0);
        {rdaddr, result, storedata, pcplus4, imm} = '0;
    endtask

    // One doubleword store per memory row, so every later load reads known data.
    task automatic fill_memory();
        for (int i = 0; i < DWORDS; i++)
        begin
            @(negedge clk);
            clear_inputs();
            opcode    = riscv_em_pkg::OPC_STORE;
            storesrc  = riscv_em_pkg::ST_D;
            result    = XLEN'(i) << 3;
            storedata = fill_word(result);
        end
    endtask

    task automatic drive_random();
        int              pick;
        int              size_log;
        logic            mis;
        logic            reuse;
        logic [XLEN-1:0] addr;
        pick      = $unsigned($random(seed)) % 6;
        stall     = (($random(seed) & 7) == 0);
        flush     = (($random(seed) & 15) == 0);
        mis       = (($random(seed) & 15) == 0);
        reuse     = (($random(seed) & 1) == 0);
        regw      = 1'b1;
        rdaddr    = 5'($random(seed));
        memext    = riscv_em_pkg::memext_e'(3'($unsigned($random(seed)) % 7));
        storesrc  = riscv_em_pkg::storesrc_e'(2'($random(seed)));
        result    = {$random(seed), $random(seed)};
        storedata = {$random(seed), $random(seed)};
        pcplus4   = {$random(seed), $random(seed)};
        imm       = {$random(seed), $random(seed)};
        ld_mis    = 1'b0;
        st_mis    = 1'b0;
        resultsrc = riscv_em_pkg::RES_ALU;
        size_log  = 0;
        case (pick)
            0:
            begin
                opcode    = riscv_em_pkg::OPC_LOAD;
                resultsrc = riscv_em_pkg::RES_MEM;
                size_log  = int'(memext[1:0]);
                ld_mis    = mis;
            end
            1:
            begin
                opcode    = riscv_em_pkg::OPC_STORE;
                regw      = 1'b0;
                size_log  = int'(storesrc);
                st_mis    = mis;
            end
            2: opcode = riscv_em_pkg::OPC_OP;
            3: opcode = riscv_em_pkg::OPC_OP_IMM;
            4:
            begin
                opcode    = riscv_em_pkg::OPC_LUI;
                resultsrc = riscv_em_pkg::RES_IMM;
            end
            default:
            begin
                opcode    = riscv_em_pkg::OPC_JAL;
                resultsrc = riscv_em_pkg::RES_PC4;
            end
        endcase
        if (pick < 2)
        begin
            addr = (pick == 0 && reuse) ? last_addr : result; // Loads often hit the last store.
            addr[XLEN-1:ABITS] = '0;
            addr = addr & ~((XLEN'(1) << size_log) - XLEN'(1));
            if (mis)
                addr[0] = 1'b1;
            result = addr;
            if (pick == 1)
                last_addr = addr;
        end
        if (!stall && !flush)
            issued++;
    endtask

    initial
    begin
        seed      = 35490;
        rst       = 1'b1;
        cycles    = 0;
        issued    = 0;
        last_addr = '0;
        clear_inputs();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        fill_memory();
        while (issued < NUM_INSTR)
        begin
            @(negedge clk);
            drive_random();
        end
        @(negedge clk);
        clear_inputs();
        flush = 1'b1; // Drain with bubbles.
        repeat (2) @(negedge clk);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d, instructions: %0d", chk_count, err_count, issued);
        if (err_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/riscv_em_pkg.sv
source/riscv_ppreg_em.sv
source/riscv_store_align.sv
source/riscv_dmem.sv
source/riscv_mem_result.sv
source/riscv_mem_stage.sv
verification/riscv_mem_checker.sv
verification/tb_riscv_mem_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_riscv_mem_stage
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
